//--- tests/tile_stimulus.txt
# P sof px0 .. px7 : one pixel row, all hex; sof marks the first pixel of the row
# T tile_i tile_j sum : expected tile result in output order, hex; F : fault expected at the end
# row before the first sof, dropped
P 0 AA 55 AA 55 AA 55 AA 55
# frame 1, pixel = 16*y + x
P 1 00 01 02 03 04 05 06 07
P 0 10 11 12 13 14 15 16 17
P 0 20 21 22 23 24 25 26 27
P 0 30 31 32 33 34 35 36 37
P 0 40 41 42 43 44 45 46 47
P 0 50 51 52 53 54 55 56 57
P 0 60 61 62 63 64 65 66 67
P 0 70 71 72 73 74 75 76 77
T 0 0 198
T 0 1 1D8
T 1 0 598
T 1 1 5D8
# frame 2, pixel = ff - 16*y - x
P 1 FF FE FD FC FB FA F9 F8
P 0 EF EE ED EC EB EA E9 E8
P 0 DF DE DD DC DB DA D9 D8
P 0 CF CE CD CC CB CA C9 C8
P 0 BF BE BD BC BB BA B9 B8
P 0 AF AE AD AC AB AA A9 A8
P 0 9F 9E 9D 9C 9B 9A 99 98
P 0 8F 8E 8D 8C 8B 8A 89 88
T 0 0 E58
T 0 1 E18
T 1 0 A58
T 1 1 A18
# partial frame 3, a second sof in its third row
P 1 01 02 03 04 05 06 07 08
P 0 11 12 13 14 15 16 17 18
P 1 21 22 23 24 25 26 27 28
F

//--- all.f
logic/tile_pkg.sv
logic/pixel_xy_counter.sv
logic/frame_ctrl.sv
logic/tile_accum.sv
logic/tile_stats_top.sv
tests/tile_stats_checker.sv
tests/tile_stats_tb.sv

//--- Makefile
# Verilator build and run of the tile statistics testbench
VERILATOR ?= verilator
TOP       ?= tile_stats_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)
STIM := tests/tile_stimulus.txt

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass is decided from the log
run: $(BIN) $(STIM)
	$(BIN) | tee $(LOG)
	@if grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tile_stats_tb.sv
// testbench for the tile statistics top: replays the stimulus file with random gaps and stalls
module tile_stats_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import tile_pkg::*;

  localparam logic [31:0] seed      = 32'hd7221b8d;
  localparam string       stim_file = "tests/tile_stimulus.txt";
  // cycles watched after the last result
  localparam int          tail_cycles = 20;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   pix_valid;
  logic                   pix_ready;
  logic [pix_w-1:0]       pix_data;
  logic                   sof;
  logic                   tile_valid;
  logic                   tile_ready;
  tile_result_t           tile;
  logic                   frame_done;
  logic [frame_cnt_w-1:0] frame_cnt;
  logic                   fault;

  // {sof, data} for every pixel in file order
  logic [pix_w:0] pix_q [$];
  tile_result_t   exp_tiles [$];
  logic           exp_fault   = 1'b0;
  int             exp_frames  = 0;
  int             done_count  = 0;
  int             cycles      = 0;
  int             cycle_limit = 0;
  logic [31:0]    rng_gap     = seed;
  logic [31:0]    rng_bp      = seed;

  always #20 clk = ~clk;

  tile_stats_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .pix_data   (pix_data),
    .sof        (sof),
    .tile_valid (tile_valid),
    .tile_ready (tile_ready),
    .tile       (tile),
    .frame_done (frame_done),
    .frame_cnt  (frame_cnt),
    .fault      (fault)
  );

  bind tile_stats_top tile_stats_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .tile_valid (tile_valid),
    .tile_ready (tile_ready),
    .tile       (tile),
    .fault      (fault)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    if (got !== want) begin
      $display("[FAIL] %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
      abort_run("value mismatch");
    end
  endtask

  // ------------------------------------------------------------
  // stimulus file
  // ------------------------------------------------------------
  task automatic load_stimulus();
    int               fd;
    int               code;
    int               row_sof;
    int               rows;
    logic             in_frame;
    string            tag;
    string            rest;
    logic [pix_w-1:0] px;
    logic [31:0]      ti;
    logic [31:0]      tj;
    logic [31:0]      ts;
    tile_result_t     t;
    rows     = 0;
    in_frame = 1'b0;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else if (tag == "P") begin
          code = $fscanf(fd, "%h", row_sof);
          for (int k = 0; k < active_w; k++) begin
            code = code + $fscanf(fd, "%h", px);
            pix_q.push_back({(row_sof != 0) && (k == 0), px});
          end
          if (code != active_w + 1) begin
            abort_run("malformed pixel row in the stimulus file");
          end
          // a frame counts once all its rows follow one sof
          if (row_sof != 0) begin
            rows     = 1;
            in_frame = 1'b1;
          end else if (in_frame) begin
            rows = rows + 1;
          end
          if (in_frame && rows == active_h) begin
            exp_frames = exp_frames + 1;
            in_frame   = 1'b0;
          end
        end else if (tag == "T") begin
          code = $fscanf(fd, "%h %h %h", ti, tj, ts);
          if (code != 3) begin
            abort_run("malformed tile line in the stimulus file");
          end
          t.tile_i = ti[tile_row_w-1:0];
          t.tile_j = tj[tile_col_w-1:0];
          t.sum    = ts[sum_w-1:0];
          exp_tiles.push_back(t);
        end else if (tag == "F") begin
          exp_fault = 1'b1;
        end else begin
          abort_run({"unknown line type in the stimulus file: ", tag});
        end
      end
      $fclose(fd);
    end
  endtask

  // one pixel, after a random idle gap, held until taken or the DUT halts
  task automatic send_pixel(input logic [pix_w:0] p, output logic halted);
    logic accepted;
    int   gap;
    accepted = 1'b0;
    halted   = 1'b0;
    rng_gap  = xorshift(rng_gap);
    gap      = (rng_gap[9:8] == 2'b00) ? int'(rng_gap[11:10]) + 1 : 0;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    pix_valid = 1'b1;
    sof       = p[pix_w];
    pix_data  = p[pix_w-1:0];
    while (!accepted && !halted) begin
      @(posedge clk);
      accepted = pix_ready;
      halted   = fault && !pix_ready;
      #2;
    end
    pix_valid = 1'b0;
    sof       = 1'b0;
  endtask

  // ------------------------------------------------------------
  // monitors
  // ------------------------------------------------------------
  // random output stall, ready three cycles in four
  always @(posedge clk) begin
    #2;
    rng_bp     = xorshift(rng_bp);
    tile_ready = (rng_bp[1:0] != 2'b00);
  end

  always @(posedge clk) begin : watch_tiles
    tile_result_t want;
    if (!rst && tile_valid && tile_ready) begin
      if (exp_tiles.size() == 0) begin
        abort_run("a tile result arrived that the stimulus does not expect");
      end else begin
        want = exp_tiles.pop_front();
        expect_equal("tile_i", 32'(tile.tile_i), 32'(want.tile_i));
        expect_equal("tile_j", 32'(tile.tile_j), 32'(want.tile_j));
        expect_equal("tile sum", 32'(tile.sum), 32'(want.sum));
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && frame_done) begin
      done_count <= done_count + 1;
    end
  end

  // limit set once the pixel count is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      abort_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    logic halted;
    rst        = 1'b1;
    pix_valid  = 1'b0;
    pix_data   = '0;
    sof        = 1'b0;
    tile_ready = 1'b0;
    halted     = 1'b0;
    load_stimulus();
    cycle_limit = 4 * pix_q.size() + 200;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    while (pix_q.size() > 0 && !halted) begin
      send_pixel(pix_q.pop_front(), halted);
    end
    // drain results still in flight
    while (exp_tiles.size() > 0) begin
      @(posedge clk);
      #2;
    end
    repeat (tail_cycles) begin
      @(posedge clk);
      if (exp_fault) begin
        expect_equal("pix_ready after fault", 32'(pix_ready), 32'd0);
      end
      #2;
    end
    expect_equal("fault", 32'(fault), 32'(exp_fault));
    expect_equal("frame_done pulses", 32'(done_count), 32'(exp_frames));
    expect_equal("frame_cnt", 32'(frame_cnt), 32'(exp_frames));
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- tests/tile_stats_checker.sv
// assertion checker bound into the tile statistics top for output handshake and fault rules
module tile_stats_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   tile_valid,
  input logic                   tile_ready,
  input tile_pkg::tile_result_t tile,
  input logic                   fault
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------
  // tile output handshake
  // ------------------------------------------------------------
  // a stalled result keeps valid and payload
  a_tile_held: assert property (
    @(posedge clk) disable iff (rst)
      tile_valid && !tile_ready |=> tile_valid && $stable(tile)
  ) else $error("tile output changed while stalled");

  // ------------------------------------------------------------
  // fault
  // ------------------------------------------------------------
  // sticky until reset
  a_fault_sticky: assert property (
    @(posedge clk) disable iff (rst)
      fault |=> fault
  ) else $error("fault fell without a reset");

  // only a result already pending may still leave
  a_no_tile_after_fault: assert property (
    @(posedge clk) disable iff (rst)
      fault && !tile_valid |=> !tile_valid
  ) else $error("new tile result after the fault");

endmodule

//--- logic/tile_stats_top.sv
// top level of the 4x4 tile statistics block, wiring coordinate counter, frame controller and accumulator
module tile_stats_top (
  input  logic                              clk,
  input  logic                              rst,
  // pixel input
  input  logic                              pix_valid,
  output logic                              pix_ready,
  input  logic [tile_pkg::pix_w-1:0]        pix_data,
  input  logic                              sof,
  // tile output
  output logic                              tile_valid,
  input  logic                              tile_ready,
  output tile_pkg::tile_result_t            tile,
  // status
  output logic                              frame_done,
  output logic [tile_pkg::frame_cnt_w-1:0]  frame_cnt,
  output logic                              fault
);
  import tile_pkg::*;

  // counter to accumulator
  logic      beat_valid;
  logic      beat_ready;
  pix_beat_t beat;

  // controller and counter side signals
  logic keep;
  logic halt;
  logic sof_err;
  logic frame_end;

  // ------------------------------------------------------------
  // coordinate tagging
  // ------------------------------------------------------------
  pixel_xy_counter i_counter (
    .clk        (clk),
    .rst        (rst),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .sof        (sof),
    .keep       (keep),
    .halt       (halt),
    .pix_ready  (pix_ready),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_ready (beat_ready),
    .sof_err    (sof_err),
    .frame_end  (frame_end)
  );

  // frame gating and fault
  frame_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .sof        (sof),
    .sof_err    (sof_err),
    .frame_end  (frame_end),
    .keep       (keep),
    .halt       (halt),
    .frame_done (frame_done),
    .fault      (fault),
    .frame_cnt  (frame_cnt)
  );

  // tile sums
  tile_accum i_accum (
    .clk        (clk),
    .rst        (rst),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_ready (beat_ready),
    .tile_valid (tile_valid),
    .tile       (tile),
    .tile_ready (tile_ready)
  );

endmodule

//--- logic/tile_accum.sv
// sums the pixels of each 4x4 tile in per-column registers and emits one result per tile
module tile_accum (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    beat_valid,
  input  tile_pkg::pix_beat_t     beat,
  output logic                    beat_ready,
  output logic                    tile_valid,
  output tile_pkg::tile_result_t  tile,
  input  logic                    tile_ready
);
  import tile_pkg::*;

  // one running sum per tile column
  logic [sum_w-1:0] acc [tiles_x];

  logic                  pop;
  logic [tile_col_w-1:0] col;
  logic [tile_row_w-1:0] row;
  logic [sum_w-1:0]      base;
  logic [sum_w-1:0]      new_sum;

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  // stall only while a finished tile waits on the output
  assign beat_ready = !tile_valid || tile_ready;
  assign pop        = beat_valid && beat_ready;

  always_comb begin
    // column and row of the tile this pixel belongs to
    col     = beat.x[x_w-1:tile_shift];
    row     = beat.y[y_w-1:tile_shift];
    // first pixel of a tile restarts the sum
    base    = beat.tile_first ? '0 : acc[col];
    new_sum = base + {{(sum_w - pix_w){1'b0}}, beat.data};
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      acc[col] <= new_sum;
    end
  end

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      tile_valid <= 1'b0;
    end else begin
      if (tile_valid && tile_ready) begin
        tile_valid <= 1'b0;
      end
      // a new tile may replace the one leaving this cycle
      if (pop && beat.tile_last) begin
        tile_valid <= 1'b1;
      end
    end
  end

  // payload held until tile_ready
  always_ff @(posedge clk) begin
    if (pop && beat.tile_last) begin
      tile.tile_i <= row;
      tile.tile_j <= col;
      tile.sum    <= new_sum;
    end
  end

endmodule

//--- logic/frame_ctrl.sv
// frame state machine that decides which pixels are kept, counts frames and latches the sof fault
module frame_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              sof,
  input  logic                              sof_err,
  input  logic                              frame_end,
  output logic                              keep,
  output logic                              halt,
  output logic                              frame_done,
  output logic                              fault,
  output logic [tile_pkg::frame_cnt_w-1:0]  frame_cnt
);
  import tile_pkg::*;

  frame_state_t state;
  frame_state_t state_d;

  // a frame completes without a fault in the same cycle
  logic done_evt;

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb begin
    state_d  = state;
    done_evt = 1'b0;
    case (state)
      st_idle: begin
        if (sof_err) begin
          state_d = st_fault;
        end else if (sof) begin
          state_d = st_run;
        end
      end
      st_run: begin
        if (sof_err) begin
          state_d = st_fault;
        end else if (frame_end) begin
          done_evt = 1'b1;
          // the next frame's sof may already be on the input
          state_d  = sof ? st_run : st_idle;
        end
      end
      // sticky until reset
      st_fault: state_d = st_fault;
      default:  state_d = st_idle;
    endcase
  end

  // idle only lets a sof pixel through
  assign keep  = (state == st_run) || ((state == st_idle) && sof);
  assign fault = (state == st_fault);
  assign halt  = fault;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      frame_done <= 1'b0;
      frame_cnt  <= '0;
    end else begin
      state      <= state_d;
      frame_done <= done_evt;
      // counter moves together with the done pulse
      if (done_evt) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

endmodule

//--- logic/pixel_xy_counter.sv
// tags each kept pixel with its x/y coordinate and tile flags, holding it in a one-entry skid buffer
module pixel_xy_counter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        pix_valid,
  input  logic [tile_pkg::pix_w-1:0]  pix_data,
  input  logic                        sof,
  input  logic                        keep,
  input  logic                        halt,
  output logic                        pix_ready,
  output logic                        beat_valid,
  output tile_pkg::pix_beat_t         beat,
  input  logic                        beat_ready,
  output logic                        sof_err,
  output logic                        frame_end
);
  import tile_pkg::*;

  // last coordinate of a line and of a frame
  localparam logic [x_w-1:0] x_max = x_w'(active_w - 1);
  localparam logic [y_w-1:0] y_max = y_w'(active_h - 1);

  // next coordinate to hand out
  logic [x_w-1:0] x_r;
  logic [y_w-1:0] y_r;

  // low during reset so no pixel is taken in the reset cycle
  logic armed;

  logic fire_in;
  logic fire_out;
  logic push;
  logic at_origin;

  // coordinate of the incoming pixel and the step after it
  logic [x_w-1:0] x_cur;
  logic [y_w-1:0] y_cur;
  logic [x_w-1:0] x_next;
  logic [y_w-1:0] y_next;

  pix_beat_t beat_d;

  // build a beat and its tile/frame flags from a coordinate
  function automatic pix_beat_t make_beat(input logic [x_w-1:0]   bx,
                                          input logic [y_w-1:0]   by,
                                          input logic [pix_w-1:0] bd);
    pix_beat_t b;
    b.x          = bx;
    b.y          = by;
    b.data       = bd;
    // top-left pixel of a tile
    b.tile_first = (bx[tile_shift-1:0] == '0) && (by[tile_shift-1:0] == '0);
    // bottom-right pixel of a tile
    b.tile_last  = (&bx[tile_shift-1:0]) && (&by[tile_shift-1:0]);
    b.frame_last = (bx == x_max) && (by == y_max);
    return b;
  endfunction

  // ------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------
  always_comb begin
    fire_out = beat_valid && beat_ready;
    // buffer empty or draining this cycle, and controller not faulted
    pix_ready = armed && !halt && (!beat_valid || fire_out);
    fire_in   = pix_valid && pix_ready;
    // dropped pixels are still consumed but never pushed
    push      = fire_in && keep;
    at_origin = (x_r == '0) && (y_r == '0);
  end

  // ------------------------------------------------------------
  // coordinate step
  // ------------------------------------------------------------
  always_comb begin
    // sof forces the pixel onto (0,0)
    x_cur = sof ? '0 : x_r;
    y_cur = sof ? '0 : y_r;
    if (x_cur == x_max) begin
      x_next = '0;
      // wrap from (7,7) back to the origin
      y_next = (y_cur == y_max) ? '0 : y_cur + 1'b1;
    end else begin
      x_next = x_cur + 1'b1;
      y_next = y_cur;
    end
    beat_d = make_beat(x_cur, y_cur, pix_data);
  end

  // kept sof while the frame is still running
  assign sof_err   = push && sof && !at_origin;
  // last pixel of the frame leaves for the accumulator
  assign frame_end = fire_out && beat.frame_last;

  // ------------------------------------------------------------
  // control state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      armed      <= 1'b0;
      beat_valid <= 1'b0;
      x_r        <= '0;
      y_r        <= '0;
    end else begin
      armed <= 1'b1;
      if (push) begin
        // coordinate advances on every kept input
        x_r        <= x_next;
        y_r        <= y_next;
        // stays full even when popped in the same cycle
        beat_valid <= 1'b1;
      end else if (fire_out) begin
        beat_valid <= 1'b0;
      end
    end
  end

  // skid buffer payload
  always_ff @(posedge clk) begin
    if (push) begin
      beat <= beat_d;
    end
  end

endmodule

//--- logic/tile_pkg.sv
// shared geometry, widths and beat/result structs for the tile statistics datapath and its testbench
package tile_pkg;

  // ------------------------------------------------------------
  // image geometry
  // ------------------------------------------------------------
  // fixed 8x8 raster keeps simulation short
  localparam int active_w = 8;
  localparam int active_h = 8;
  localparam int x_w      = 3;
  localparam int y_w      = 3;

  // 4x4 tiles
  localparam int tile_shift = 2;
  localparam int tiles_x    = active_w >> tile_shift;
  localparam int tile_col_w = x_w - tile_shift;
  localparam int tile_row_w = y_w - tile_shift;

  // ------------------------------------------------------------
  // datapath widths
  // ------------------------------------------------------------
  localparam int pix_w = 8;
  // 16 pixels of 255 need 12 bits
  localparam int sum_w       = 12;
  localparam int frame_cnt_w = 16;

  // tagged pixel from the coordinate counter
  typedef struct packed {
    logic [x_w-1:0]   x;
    logic [y_w-1:0]   y;
    logic [pix_w-1:0] data;
    logic             tile_first;
    logic             tile_last;
    logic             frame_last;
  } pix_beat_t;

  // one finished tile
  typedef struct packed {
    logic [tile_row_w-1:0] tile_i;
    logic [tile_col_w-1:0] tile_j;
    logic [sum_w-1:0]      sum;
  } tile_result_t;

  // frame controller states
  typedef enum logic [1:0] {st_idle, st_run, st_fault} frame_state_t;

endpackage
